// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := rvCoreTb
FILELIST := rvCore.f
BUILDDIR := obj_dir
SIMBIN   := $(BUILDDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) design/rvCore_defs.svh

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(SIMBIN)
	-./$(SIMBIN) | tee $(LOG)
	@! grep -q "test failed" $(LOG) && grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: design/decodeStage.sv
`include "rvCore_defs.svh"

module decodeStage import rvCorePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  instr_t  iMemData,
    input  wbPort_t wb,
    output logic    stallN,
    output idEx_t   idEx
);

    logic   firstCycle;
    instr_t instr;
    word_t  rs1Val, rs2Val;
    logic   usesRs2;
    idEx_t  decoded;

    function automatic aluOp_e aluFromFunct3(input logic [2:0] f3);
        case (f3)
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    // sll / srl / sra codes, not supported
    function automatic logic isShift(input logic [2:0] f3);
        return f3[1:0] == 2'b01;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            firstCycle <= 1'b1;
        end else begin
            firstCycle <= 1'b0;
        end
    end

    // memory output not valid yet in the first cycle
    assign instr = firstCycle ? instr_t'(`NOP_INSTR) : iMemData;

    regFile rf (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (instr.r.rs1),
        .rs2Addr (instr.r.rs2),
        .wb      (wb),
        .rs1Data (rs1Val),
        .rs2Data (rs2Val)
    );

    always_comb begin
        decoded         = '0;
        decoded.rs1Data = rs1Val;
        decoded.rs2Data = rs2Val;
        decoded.rs1     = instr.r.rs1;
        decoded.rs2     = instr.r.rs2;
        decoded.rd      = instr.r.rd;
        decoded.imm     = {{(`WORD_WIDTH-12){instr.i.imm[11]}}, instr.i.imm};
        decoded.aluOp   = aluAdd;
        usesRs2         = 1'b0;
        case (instr.r.opcode)
            opcOp: begin
                usesRs2 = 1'b1;
                decoded.aluOp = (instr.r.funct7 == `FUNCT7_SUB) ? aluSub
                                                                 : aluFromFunct3(instr.r.funct3);
                decoded.regWrite = !isShift(instr.r.funct3) &&
                    (instr.r.funct7 == '0 ||
                     (instr.r.funct3 == 3'b000 && instr.r.funct7 == `FUNCT7_SUB));
            end
            opcOpImm: begin
                decoded.aluOp    = aluFromFunct3(instr.i.funct3);
                decoded.useImm   = 1'b1;
                decoded.regWrite = !isShift(instr.i.funct3);
            end
            opcLoad: begin
                decoded.useImm   = 1'b1;   // address = rs1 + imm
                decoded.memRead  = instr.i.funct3 == `FUNCT3_WORD;
                decoded.regWrite = instr.i.funct3 == `FUNCT3_WORD;
            end
            opcStore: begin
                usesRs2          = 1'b1;
                decoded.imm      = {{(`WORD_WIDTH-12){instr.s.immHi[6]}},
                                    instr.s.immHi, instr.s.immLo};
                decoded.useImm   = 1'b1;
                decoded.memWrite = instr.s.funct3 == `FUNCT3_WORD;
            end
            default: ;   // unknown word acts as nop
        endcase
    end

    // load in execute feeding the word in decode
    assign stallN = !(idEx.memRead && idEx.rd != '0 &&
                      (idEx.rd == instr.r.rs1 || (usesRs2 && idEx.rd == instr.r.rs2)));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else begin
            idEx <= decoded;
            if (!stallN) begin
                idEx.memRead  <= 1'b0;   // bubble
                idEx.memWrite <= 1'b0;
                idEx.regWrite <= 1'b0;
            end
        end
    end

endmodule

// File: design/executeStage.sv
module executeStage import rvCorePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  idEx_t    idEx,
    input  wbPort_t  wb,
    output exMem_t   exMem,
    output dMemReq_t dMemReq
);

    word_t opA, opB;
    word_t rs2Fwd;   // also the store data
    word_t aluOut;

    // memory stage first, loads there are excluded
    function automatic word_t forwardOp(input regAddr_t src, input word_t regVal,
                                        input exMem_t mem, input wbPort_t wbSrc);
        if (mem.regWrite && !mem.memRead && mem.rd != '0 && mem.rd == src) begin
            return mem.aluResult;
        end
        if (wbSrc.regWrite && wbSrc.rd != '0 && wbSrc.rd == src) begin
            return wbSrc.data;
        end
        return regVal;
    endfunction

    always_comb begin
        opA    = forwardOp(idEx.rs1, idEx.rs1Data, exMem, wb);
        rs2Fwd = forwardOp(idEx.rs2, idEx.rs2Data, exMem, wb);
        opB    = idEx.useImm ? idEx.imm : rs2Fwd;
        case (idEx.aluOp)
            aluSub:  aluOut = opA - opB;
            aluSlt:  aluOut = word_t'($signed(opA) < $signed(opB));
            aluSltu: aluOut = word_t'(opA < opB);
            aluXor:  aluOut = opA ^ opB;
            aluOr:   aluOut = opA | opB;
            aluAnd:  aluOut = opA & opB;
            default: aluOut = opA + opB;   // add, load/store address
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem <= '{
                aluResult: aluOut,
                storeData: rs2Fwd,
                rd:        idEx.rd,
                memRead:   idEx.memRead,
                memWrite:  idEx.memWrite,
                regWrite:  idEx.regWrite
            };
        end
    end

    // request straight from the stage register
    assign dMemReq = '{
        addr:  exMem.aluResult,
        wdata: exMem.storeData,
        read:  exMem.memRead,
        write: exMem.memWrite
    };

endmodule

// File: design/fetchUnit.sv
`include "rvCore_defs.svh"

module fetchUnit import rvCorePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stallN,
    output word_t iMemAddr,
    output word_t decodePc
);

    word_t pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc       <= `RESET_PC;
            decodePc <= `RESET_PC;
        end else if (stallN) begin
            pc       <= pc + `PC_STEP;
            decodePc <= pc;             // address of the word now being read
        end
    end

    // on a stall the held instruction is fetched again
    assign iMemAddr = stallN ? pc : decodePc;

endmodule

// File: design/regFile.sv
`include "rvCore_defs.svh"

module regFile import rvCorePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    input  wbPort_t  wb,
    output word_t    rs1Data,
    output word_t    rs2Data
);

    word_t regs [1:`RF_DEPTH-1];   // x0 not stored

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write shows through to the read port
    always_comb begin
        rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
        rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];
        if (wb.regWrite && wb.rd != '0 && wb.rd == rs1Addr) begin
            rs1Data = wb.data;
        end
        if (wb.regWrite && wb.rd != '0 && wb.rd == rs2Addr) begin
            rs2Data = wb.data;
        end
    end

endmodule

// File: design/resultStage.sv
module resultStage import rvCorePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  exMem_t  exMem,
    input  word_t   dMemRData,
    output wbPort_t wb
);

    logic     regWriteQ;
    logic     loadQ;
    regAddr_t rdQ;
    word_t    aluQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteQ <= 1'b0;
            loadQ     <= 1'b0;
        end else begin
            regWriteQ <= exMem.regWrite;
            loadQ     <= exMem.memRead;
        end
    end

    always_ff @(posedge clk) begin
        rdQ  <= exMem.rd;
        aluQ <= exMem.aluResult;
    end

    // load data arrives one cycle after the request
    assign wb = '{regWrite: regWriteQ, rd: rdQ, data: loadQ ? dMemRData : aluQ};

endmodule

// File: design/rvCore.sv
module rvCore import rvCorePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    // instruction memory
    output word_t    iMemAddr,
    input  instr_t   iMemData,
    // data memory
    output dMemReq_t dMemReq,
    input  word_t    dMemRData
);

    logic    stallN;
    idEx_t   idEx;
    exMem_t  exMem;
    wbPort_t wb;

    fetchUnit fetch (
        .clk      (clk),
        .rstN     (rstN),
        .stallN   (stallN),
        .iMemAddr (iMemAddr),
        .decodePc ()            // no branches, pc not consumed downstream
    );

    decodeStage decode (
        .clk      (clk),
        .rstN     (rstN),
        .iMemData (iMemData),
        .wb       (wb),
        .stallN   (stallN),
        .idEx     (idEx)
    );

    executeStage execute (
        .clk     (clk),
        .rstN    (rstN),
        .idEx    (idEx),
        .wb      (wb),          // older forwarding source
        .exMem   (exMem),
        .dMemReq (dMemReq)
    );

    resultStage result (
        .clk       (clk),
        .rstN      (rstN),
        .exMem     (exMem),
        .dMemRData (dMemRData),
        .wb        (wb)
    );

endmodule

// File: design/rvCorePkg.sv
`include "rvCore_defs.svh"

package rvCorePkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`RF_ADDR_WIDTH-1:0] regAddr_t;

    typedef struct packed {
        logic [6:0] funct7;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        regAddr_t   rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        regAddr_t    rs1;
        logic [2:0]  funct3;
        regAddr_t    rd;
        logic [6:0]  opcode;
    } iType_t;

    // immediate split around the rd field
    typedef struct packed {
        logic [6:0] immHi;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
    } instr_t;

    typedef enum logic [6:0] {
        opcOp    = 7'b0110011,
        opcOpImm = 7'b0010011,
        opcLoad  = 7'b0000011,
        opcStore = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluSlt, aluSltu, aluXor, aluOr, aluAnd
    } aluOp_e;

    typedef struct packed {
        word_t    rs1Data;
        word_t    rs2Data;
        word_t    imm;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        aluOp_e   aluOp;
        logic     useImm;
        logic     memRead;
        logic     memWrite;
        logic     regWrite;
    } idEx_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    storeData;
        regAddr_t rd;
        logic     memRead;
        logic     memWrite;
        logic     regWrite;
    } exMem_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } dMemReq_t;

    typedef struct packed {
        logic     regWrite;
        regAddr_t rd;
        word_t    data;
    } wbPort_t;

endpackage

// File: design/rvCore_defs.svh
`ifndef RVCORE_DEFS_SVH
`define RVCORE_DEFS_SVH

// datapath widths
`define WORD_WIDTH 32
`define RF_ADDR_WIDTH 5
`define RF_DEPTH 32

// fetch
`define PC_STEP 32'd4
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`define FUNCT3_WORD 3'b010   // lw / sw width field
`define FUNCT7_SUB 7'b0100000

`endif

// File: rvCore.f
+incdir+design
design/rvCorePkg.sv
design/regFile.sv
design/fetchUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/rvCore.sv
tb/rvCoreMem.sv
tb/rvCoreTb.sv

// File: tb/rvCoreMem.sv
`include "rvCore_defs.svh"

module rvCoreMem import rvCorePkg::*; (
    input  logic     clk,
    input  word_t    iMemAddr,
    output instr_t   iMemData,
    input  dMemReq_t dMemReq,
    output word_t    dMemRData
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int memWords = 256;   // 1 KiB each

    word_t  imem [memWords];
    word_t  dmem [memWords];
    instr_t iWord = instr_t'(`NOP_INSTR);   // defined before the first clock edge
    word_t  rWord = '0;

    // one cycle of read latency on both ports
    always @(posedge clk) begin
        iWord <= instr_t'(imem[iMemAddr[9:2]]);
        if (dMemReq.read) begin
            rWord <= dmem[dMemReq.addr[9:2]];
        end
        if (dMemReq.write) begin
            dmem[dMemReq.addr[9:2]] <= dMemReq.wdata;
        end
    end

    assign iMemData  = iWord;
    assign dMemRData = rWord;

endmodule

// File: tb/rvCoreTb.sv
`include "rvCore_defs.svh"

module rvCoreTb import rvCorePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {opAdd, opSub, opSlt, opSltu, opXor, opOr, opAnd} testOp_e;

    typedef struct packed {
        testOp_e     op;
        logic        immForm;   // register or immediate operand
        logic [11:0] imm;
        regAddr_t    dst;
    } case_t;

    localparam int numCases = 16;
    localparam int resultBase = 'h100;   // byte address of the stored results
    localparam int storeTimeout = 32;
    localparam logic [6:0] loadOpc = 7'b0000011;
    localparam logic [6:0] storeOpc = 7'b0100011;
    localparam logic [6:0] opImmOpc = 7'b0010011;
    localparam logic [6:0] opOpc = 7'b0110011;

    case_t caseTable [numCases] = '{
        '{opAdd,  1'b0, 12'h001, 5'd3}, '{opSub,  1'b0, 12'h7ff, 5'd3},
        '{opSlt,  1'b0, 12'h800, 5'd3}, '{opSltu, 1'b0, 12'h123, 5'd3},
        '{opXor,  1'b0, 12'hfff, 5'd3}, '{opOr,   1'b0, 12'h055, 5'd3},
        '{opAnd,  1'b0, 12'h0aa, 5'd3}, '{opAdd,  1'b1, 12'h7ff, 5'd3},
        '{opAdd,  1'b1, 12'h800, 5'd3}, '{opSlt,  1'b1, 12'h800, 5'd3},
        '{opSltu, 1'b1, 12'hfff, 5'd3}, '{opXor,  1'b1, 12'h800, 5'd3},
        '{opOr,   1'b1, 12'h7ff, 5'd3}, '{opAnd,  1'b1, 12'hf0f, 5'd3},
        '{opAdd,  1'b0, 12'h321, 5'd0}, '{opSlt,  1'b1, 12'h7ff, 5'd3}   // x0 as target
    };

    logic     clk = 1'b0;
    logic     rstN = 1'b0;
    word_t    iMemAddr;
    instr_t   iMemData;
    dMemReq_t dMemReq;
    word_t    dMemRData;
    word_t    lfsrState;
    int       progLen;
    dMemReq_t expStores [$];

    rvCore UUT (.clk, .rstN, .iMemAddr, .iMemData, .dMemReq, .dMemRData);
    rvCoreMem memModel (.clk, .iMemAddr, .iMemData, .dMemReq, .dMemRData);

    always #50 clk = ~clk;

    function automatic word_t lfsrNext(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois, x^32+x^22+x^2+x+1
    endfunction

    function automatic word_t randWord();
        word_t w;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsrState[0]};   // one step per bit
            lfsrState = lfsrNext(lfsrState);
        end
        return w;
    endfunction

    function automatic word_t sext(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [2:0] funct3Of(input testOp_e op);
        case (op)
            opSlt:   return 3'b010;
            opSltu:  return 3'b011;
            opXor:   return 3'b100;
            opOr:    return 3'b110;
            opAnd:   return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    // architectural result of one RV32I operation
    function automatic word_t expectedResult(input testOp_e op, input word_t a, input word_t b);
        case (op)
            opSub:   return a - b;
            opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opSltu:  return (a < b) ? 32'd1 : 32'd0;
            opXor:   return a ^ b;
            opOr:    return a | b;
            opAnd:   return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic word_t encI(input logic [11:0] imm, input regAddr_t rs1,
                                   input logic [2:0] f3, input regAddr_t rd,
                                   input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input regAddr_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], storeOpc};   // sw rs2, imm(x0)
    endfunction

    task automatic emit(input word_t w);
        memModel.imem[progLen] = w;
        progLen++;
    endtask

    task automatic buildProgram();
        word_t a;
        word_t b;
        word_t dstVal;
        int    resAddr;
        case_t c;
        for (int i = 0; i < 256; i++) begin
            memModel.imem[i] = `NOP_INSTR;   // padding after the program
            memModel.dmem[i] = {~16'(i), 16'(i)};
        end
        progLen = 0;
        for (int k = 0; k < numCases; k++) begin
            c = caseTable[k];
            a = randWord();
            b = randWord();
            memModel.dmem[2*k] = a;
            memModel.dmem[2*k+1] = b;
            resAddr = resultBase + 8*k;
            dstVal = (c.dst == 5'd0) ? '0 : expectedResult(c.op, a, c.immForm ? sext(c.imm) : b);
            emit(encI(12'(8*k), 5'd0, 3'b010, 5'd1, loadOpc));
            emit(encI(12'(8*k+4), 5'd0, 3'b010, 5'd2, loadOpc));
            if (c.immForm) begin
                emit(encI(c.imm, 5'd1, funct3Of(c.op), c.dst, opImmOpc));
            end else begin
                emit({(c.op == opSub) ? 7'b0100000 : 7'b0, 5'd2, 5'd1, funct3Of(c.op),
                      c.dst, opOpc});   // x2 used right after its load
            end
            emit(encS(12'(resAddr), c.dst));
            emit(encI(c.imm, c.dst, 3'b000, 5'd4, opImmOpc));
            emit(encS(12'(resAddr + 4), 5'd4));
            expStores.push_back('{addr: resAddr, wdata: dstVal, read: 1'b0, write: 1'b1});
            expStores.push_back('{addr: resAddr + 4, wdata: dstVal + sext(c.imm),
                                  read: 1'b0, write: 1'b1});
        end
    endtask

    task automatic abortRun();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkStore(input dMemReq_t got, input dMemReq_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: store addr %h data %h, expected addr %h data %h",
                     $time, got.addr, got.wdata, exp.addr, exp.wdata);
            abortRun();
        end
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic waitStore(input int n);
        int cycles;
        cycles = 0;
        while (!dMemReq.write) begin
            if (cycles == storeTimeout) begin
                $display("store %0d to address %h never arrived", n, expStores[n].addr);
                abortRun();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    initial begin
        lfsrState = 32'h743e;
        buildProgram();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            checkBit(dMemReq.read, 1'b0, "read strobe in reset");
            checkBit(dMemReq.write, 1'b0, "write strobe in reset");
        end
        rstN = 1'b1;
        checkWord(iMemAddr, `RESET_PC, "first fetch address");
        repeat (2) begin
            @(negedge clk);
            checkBit(dMemReq.read, 1'b0, "read strobe after reset");
            checkBit(dMemReq.write, 1'b0, "write strobe after reset");
        end
        for (int n = 0; n < expStores.size(); n++) begin
            waitStore(n);
            checkStore(dMemReq, expStores[n]);
            @(negedge clk);
        end
        // only nops remain, so no further store may show up
        repeat (24) begin
            @(negedge clk);
            if (dMemReq.write) begin
                $display("unexpected extra store to address %h", dMemReq.addr);
                abortRun();
            end
        end
        $display("test passed");
        $finish;
    end

endmodule
